// ==== src/l2_cache_pkg.sv ====
// Shared types and constants for the L2 tag pipeline, imported by every L2 metadata module
`default_nettype none

package l2_cache_pkg;

	// Associativity is fixed by the 3-bit tree pseudo-LRU
	localparam int NUM_WAYS = 4;

	// Width of the invalidate mask, one bit per possible core
	localparam int MAX_CORES = 16;

	// Cache-line address. Low bits pick the set and the rest form the tag
	typedef logic [19:0] line_addr_t;

	typedef logic [1:0] way_t;

	typedef logic [3:0] core_id_t;

	typedef enum logic [1:0] {
		L2_LOAD,
		L2_STORE,
		L2_FLUSH,
		L2_INVALIDATE
	} l2_op_e;

	// Actions on the sharer vector of one line
	typedef enum logic [1:0] {
		SHR_ADD,
		SHR_ONLY,
		SHR_CLEAR,
		SHR_KEEP
	} shr_op_e;

	typedef struct packed {
		logic       valid;
		core_id_t   core;
		l2_op_e     op;
		line_addr_t addr;
	} l2_req_t;

	typedef struct packed {
		logic                 valid;
		logic                 hit;
		way_t                 way;
		logic                 writeback;
		line_addr_t           wb_addr;
		logic [MAX_CORES-1:0] inval_mask;
		l2_op_e               op;
	} l2_resp_t;

endpackage

`default_nettype wire

// ==== src/sram_1r1w.sv ====
// Generic one-read one-write memory with registered read, used for the tag and dirty arrays
`timescale 1ns/1ns
`default_nettype none

module sram_1r1w
#(
	parameter int DATA_WIDTH = 8,
	parameter int DEPTH = 16
)
(
	input  logic                     clk,
	input  logic                     rd_en_i,
	input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
	input  logic                     wr_en_i,
	input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
	input  logic [DATA_WIDTH-1:0]    wr_data_i,
	output logic [DATA_WIDTH-1:0]    rd_data_o
);

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;

		// A write to the address being read wins over the stored word
		if (rd_en_i)
		begin
			if (wr_en_i && wr_addr_i == rd_addr_i)
				rd_data_o <= wr_data_i;
			else
				rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

`default_nettype wire

// ==== src/cache_lru.sv ====
// Tree pseudo-LRU state for a 4-way cache, giving a registered victim way per set lookup
`timescale 1ns/1ns
`default_nettype none

module cache_lru
#(
	parameter int SET_BITS = 4
)
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      rd_en_i,
	input  logic [SET_BITS-1:0]       rd_set_i,
	output l2_cache_pkg::way_t        victim_o,
	input  logic                      upd_en_i,
	input  logic [SET_BITS-1:0]       upd_set_i,
	input  l2_cache_pkg::way_t        upd_way_i
);

	import l2_cache_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;

	// Bit 0 picks the half, bit 1 the way in the low half, bit 2 the way in the high half
	logic [2:0] tree_q [NUM_SETS];
	logic [2:0] upd_tree;
	logic [2:0] rd_tree;

	// Point every node on the path of the used way at the other side
	function automatic logic [2:0] touch(input logic [2:0] tree, input way_t way);
		logic [2:0] next;
		next = tree;
		next[0] = ~way[1];
		if (way[1])
			next[2] = ~way[0];
		else
			next[1] = ~way[0];
		return next;
	endfunction

	function automatic way_t pick(input logic [2:0] tree);
		way_t way;
		way[1] = tree[0];
		way[0] = tree[0] ? tree[2] : tree[1];
		return way;
	endfunction

	assign upd_tree = touch(tree_q[upd_set_i], upd_way_i);
	assign rd_tree = (upd_en_i && upd_set_i == rd_set_i) ? upd_tree : tree_q[rd_set_i];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_SETS; i++)
				tree_q[i] <= '0;
			victim_o <= '0;
		end
		else
		begin
			if (upd_en_i)
				tree_q[upd_set_i] <= upd_tree;
			if (rd_en_i)
				victim_o <= pick(rd_tree);
		end
	end

endmodule

`default_nettype wire

// ==== src/l2_sharer_dir.sv ====
// Sharer directory that tracks which L1 caches hold each L2 line, read once per request
`timescale 1ns/1ns
`default_nettype none

module l2_sharer_dir
#(
	parameter int SET_BITS = 4,
	parameter int NUM_CORES = 4
)
(
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           rd_en_i,
	input  logic [SET_BITS-1:0]            rd_set_i,
	output logic [l2_cache_pkg::NUM_WAYS-1:0][NUM_CORES-1:0] sharers_o,
	input  logic                           upd_en_i,
	input  logic [SET_BITS-1:0]            upd_set_i,
	input  l2_cache_pkg::way_t             upd_way_i,
	input  l2_cache_pkg::core_id_t         upd_core_i,
	input  l2_cache_pkg::shr_op_e          upd_op_i
);

	import l2_cache_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;

	logic [NUM_WAYS-1:0][NUM_CORES-1:0] shr_q [NUM_SETS];
	logic [NUM_WAYS-1:0][NUM_CORES-1:0] upd_row;
	logic [NUM_CORES-1:0] core_bit;

	assign core_bit = NUM_CORES'(1) << upd_core_i;

	// New contents of the whole set after the update of one way
	always_comb
	begin
		upd_row = shr_q[upd_set_i];
		case (upd_op_i)
			SHR_ADD:   upd_row[upd_way_i] = upd_row[upd_way_i] | core_bit;
			SHR_ONLY:  upd_row[upd_way_i] = core_bit;
			SHR_CLEAR: upd_row[upd_way_i] = '0;
			default:   upd_row[upd_way_i] = upd_row[upd_way_i];
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_SETS; i++)
				shr_q[i] <= '0;
			sharers_o <= '0;
		end
		else
		begin
			if (upd_en_i)
				shr_q[upd_set_i] <= upd_row;

			// Same-set update is visible to the lookup in the same cycle
			if (rd_en_i)
			begin
				if (upd_en_i && upd_set_i == rd_set_i)
					sharers_o <= upd_row;
				else
					sharers_o <= shr_q[rd_set_i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/l2_cache_tag.sv ====
// First L2 pipeline stage, which reads all set metadata and passes the request to the directory stage
`timescale 1ns/1ns
`default_nettype none

module l2_cache_tag
#(
	parameter int SET_BITS = 4,
	parameter int NUM_CORES = 4,
	localparam int TAG_BITS = $bits(l2_cache_pkg::line_addr_t) - SET_BITS
)
(
	input  logic                                             clk,
	input  logic                                             reset,
	input  l2_cache_pkg::l2_req_t                            req_i,
	output l2_cache_pkg::l2_req_t                            tag_req_o,
	output logic [l2_cache_pkg::NUM_WAYS-1:0][TAG_BITS-1:0]  tag_tags_o,
	output logic [l2_cache_pkg::NUM_WAYS-1:0]                tag_valid_o,
	output logic [l2_cache_pkg::NUM_WAYS-1:0]                tag_dirty_o,
	output l2_cache_pkg::way_t                               tag_victim_o,
	output logic [l2_cache_pkg::NUM_WAYS-1:0][NUM_CORES-1:0] tag_sharers_o,
	input  logic                                             tag_wr_en_i,
	input  logic [SET_BITS-1:0]                              tag_wr_set_i,
	input  l2_cache_pkg::way_t                               tag_wr_way_i,
	input  logic [TAG_BITS-1:0]                              tag_wr_tag_i,
	input  logic                                             tag_wr_valid_i,
	input  logic [l2_cache_pkg::NUM_WAYS-1:0]                dirty_wr_en_i,
	input  logic [SET_BITS-1:0]                              dirty_wr_set_i,
	input  logic                                             dirty_wr_value_i,
	input  logic                                             lru_upd_en_i,
	input  logic [SET_BITS-1:0]                              lru_upd_set_i,
	input  l2_cache_pkg::way_t                               lru_upd_way_i,
	input  logic                                             shr_upd_en_i,
	input  logic [SET_BITS-1:0]                              shr_upd_set_i,
	input  l2_cache_pkg::way_t                               shr_upd_way_i,
	input  l2_cache_pkg::core_id_t                           shr_upd_core_i,
	input  l2_cache_pkg::shr_op_e                            shr_upd_op_i
);

	import l2_cache_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;

	logic [SET_BITS-1:0] rd_set;
	logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
	logic [NUM_WAYS-1:0] valid_fwd;

	assign rd_set = req_i.addr[SET_BITS-1:0];

	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_way
		sram_1r1w #(
			.DATA_WIDTH(TAG_BITS),
			.DEPTH(NUM_SETS)
		) tag_mem_inst (
			.clk(clk),
			.rd_en_i(req_i.valid),
			.rd_addr_i(rd_set),
			.wr_en_i(tag_wr_en_i && tag_wr_way_i == way_t'(w)),
			.wr_addr_i(tag_wr_set_i),
			.wr_data_i(tag_wr_tag_i),
			.rd_data_o(tag_tags_o[w])
		);

		sram_1r1w #(
			.DATA_WIDTH(1),
			.DEPTH(NUM_SETS)
		) dirty_mem_inst (
			.clk(clk),
			.rd_en_i(req_i.valid),
			.rd_addr_i(rd_set),
			.wr_en_i(dirty_wr_en_i[w]),
			.wr_addr_i(dirty_wr_set_i),
			.wr_data_i(dirty_wr_value_i),
			.rd_data_o(tag_dirty_o[w])
		);
	end

	cache_lru #(
		.SET_BITS(SET_BITS)
	) lru_inst (
		.clk(clk),
		.reset(reset),
		.rd_en_i(req_i.valid),
		.rd_set_i(rd_set),
		.victim_o(tag_victim_o),
		.upd_en_i(lru_upd_en_i),
		.upd_set_i(lru_upd_set_i),
		.upd_way_i(lru_upd_way_i)
	);

	l2_sharer_dir #(
		.SET_BITS(SET_BITS),
		.NUM_CORES(NUM_CORES)
	) sharer_dir_inst (
		.clk(clk),
		.reset(reset),
		.rd_en_i(req_i.valid),
		.rd_set_i(rd_set),
		.sharers_o(tag_sharers_o),
		.upd_en_i(shr_upd_en_i),
		.upd_set_i(shr_upd_set_i),
		.upd_way_i(shr_upd_way_i),
		.upd_core_i(shr_upd_core_i),
		.upd_op_i(shr_upd_op_i)
	);

	// Valid bits live in flops so that reset empties the whole cache
	always_comb
	begin
		valid_fwd = valid_q[rd_set];
		if (tag_wr_en_i && tag_wr_set_i == rd_set)
			valid_fwd[tag_wr_way_i] = tag_wr_valid_i;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_SETS; i++)
				valid_q[i] <= '0;
			tag_valid_o <= '0;
			tag_req_o <= '0;
		end
		else
		begin
			if (tag_wr_en_i)
				valid_q[tag_wr_set_i][tag_wr_way_i] <= tag_wr_valid_i;
			if (req_i.valid)
				tag_valid_o <= valid_fwd;
			tag_req_o <= req_i;
		end
	end

endmodule

`default_nettype wire

// ==== src/l2_cache_dir.sv ====
// Second L2 pipeline stage, which resolves hit or fill, drives metadata updates and registers the response
`timescale 1ns/1ns
`default_nettype none

module l2_cache_dir
#(
	parameter int SET_BITS = 4,
	parameter int NUM_CORES = 4,
	localparam int TAG_BITS = $bits(l2_cache_pkg::line_addr_t) - SET_BITS
)
(
	input  logic                                             clk,
	input  logic                                             reset,
	input  l2_cache_pkg::l2_req_t                            tag_req_i,
	input  logic [l2_cache_pkg::NUM_WAYS-1:0][TAG_BITS-1:0]  tag_tags_i,
	input  logic [l2_cache_pkg::NUM_WAYS-1:0]                tag_valid_i,
	input  logic [l2_cache_pkg::NUM_WAYS-1:0]                tag_dirty_i,
	input  l2_cache_pkg::way_t                               tag_victim_i,
	input  logic [l2_cache_pkg::NUM_WAYS-1:0][NUM_CORES-1:0] tag_sharers_i,
	output logic                                             tag_wr_en_o,
	output logic [SET_BITS-1:0]                              tag_wr_set_o,
	output l2_cache_pkg::way_t                               tag_wr_way_o,
	output logic [TAG_BITS-1:0]                              tag_wr_tag_o,
	output logic                                             tag_wr_valid_o,
	output logic [l2_cache_pkg::NUM_WAYS-1:0]                dirty_wr_en_o,
	output logic [SET_BITS-1:0]                              dirty_wr_set_o,
	output logic                                             dirty_wr_value_o,
	output logic                                             lru_upd_en_o,
	output logic [SET_BITS-1:0]                              lru_upd_set_o,
	output l2_cache_pkg::way_t                               lru_upd_way_o,
	output logic                                             shr_upd_en_o,
	output logic [SET_BITS-1:0]                              shr_upd_set_o,
	output l2_cache_pkg::way_t                               shr_upd_way_o,
	output l2_cache_pkg::core_id_t                           shr_upd_core_o,
	output l2_cache_pkg::shr_op_e                            shr_upd_op_o,
	output l2_cache_pkg::l2_resp_t                           resp_o
);

	import l2_cache_pkg::*;

	logic [SET_BITS-1:0] set;
	logic [TAG_BITS-1:0] req_tag;
	logic [NUM_WAYS-1:0] hit_vec;
	logic                hit;
	way_t                hit_way;
	way_t                use_way;
	logic [NUM_CORES-1:0] own_bit;
	l2_resp_t            resp_d;

	assign set = tag_req_i.addr[SET_BITS-1:0];
	assign req_tag = tag_req_i.addr[$bits(line_addr_t)-1:SET_BITS];
	assign own_bit = NUM_CORES'(1) << tag_req_i.core;

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			hit_vec[w] = tag_valid_i[w] && tag_tags_i[w] == req_tag;
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
	end

	assign hit = |hit_vec;
	assign use_way = hit ? hit_way : tag_victim_i;

	// Every update addresses the set and way of the request in this stage
	assign tag_wr_set_o = set;
	assign tag_wr_way_o = use_way;
	assign tag_wr_tag_o = req_tag;
	assign dirty_wr_set_o = set;
	assign lru_upd_set_o = set;
	assign lru_upd_way_o = use_way;
	assign shr_upd_set_o = set;
	assign shr_upd_way_o = use_way;
	assign shr_upd_core_o = tag_req_i.core;

	always_comb
	begin
		tag_wr_en_o = 1'b0;
		tag_wr_valid_o = 1'b0;
		dirty_wr_en_o = '0;
		dirty_wr_value_o = 1'b0;
		lru_upd_en_o = 1'b0;
		shr_upd_en_o = 1'b0;
		shr_upd_op_o = SHR_KEEP;

		resp_d = '0;
		resp_d.valid = tag_req_i.valid;
		resp_d.hit = hit;
		resp_d.way = use_way;
		resp_d.op = tag_req_i.op;

		if (tag_req_i.valid)
		begin
			case (tag_req_i.op)
				L2_LOAD, L2_STORE:
				begin
					lru_upd_en_o = 1'b1;
					shr_upd_en_o = 1'b1;
					shr_upd_op_o = SHR_ONLY;
					if (!hit)
					begin
						// Fill the victim way, evicting whatever it held
						tag_wr_en_o = 1'b1;
						tag_wr_valid_o = 1'b1;
						dirty_wr_en_o[use_way] = 1'b1;
						dirty_wr_value_o = tag_req_i.op == L2_STORE;
						resp_d.inval_mask = MAX_CORES'(tag_sharers_i[use_way]);
						if (tag_valid_i[use_way] && tag_dirty_i[use_way])
						begin
							resp_d.writeback = 1'b1;
							resp_d.wb_addr = {tag_tags_i[use_way], set};
						end
					end
					else if (tag_req_i.op == L2_STORE)
					begin
						dirty_wr_en_o[use_way] = 1'b1;
						dirty_wr_value_o = 1'b1;
						resp_d.inval_mask = MAX_CORES'(tag_sharers_i[use_way] & ~own_bit);
					end
					else
						shr_upd_op_o = SHR_ADD;
				end

				L2_FLUSH:
				begin
					if (hit)
					begin
						dirty_wr_en_o[use_way] = 1'b1;
						resp_d.writeback = tag_dirty_i[use_way];
						resp_d.wb_addr = tag_req_i.addr;
					end
				end

				default:
				begin
					if (hit)
					begin
						tag_wr_en_o = 1'b1;
						shr_upd_en_o = 1'b1;
						shr_upd_op_o = SHR_CLEAR;
						resp_d.writeback = tag_dirty_i[use_way];
						resp_d.wb_addr = tag_req_i.addr;
						resp_d.inval_mask = MAX_CORES'(tag_sharers_i[use_way]);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			resp_o <= '0;
		else
			resp_o <= resp_d;
	end

endmodule

`default_nettype wire

// ==== src/l2_cache_tags_top.sv ====
// Top level of the L2 metadata pipeline, joining the tag stage and the directory stage
`timescale 1ns/1ns
`default_nettype none

module l2_cache_tags_top
#(
	parameter int SET_BITS = 4,
	parameter int NUM_CORES = 4
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  l2_cache_pkg::l2_req_t  req_i,
	output l2_cache_pkg::l2_resp_t resp_o
);

	import l2_cache_pkg::*;

	localparam int TAG_BITS = $bits(line_addr_t) - SET_BITS;

	// Request and metadata from the tag stage
	l2_req_t                            tag_req;
	logic [NUM_WAYS-1:0][TAG_BITS-1:0]  tag_tags;
	logic [NUM_WAYS-1:0]                tag_valid;
	logic [NUM_WAYS-1:0]                tag_dirty;
	way_t                               tag_victim;
	logic [NUM_WAYS-1:0][NUM_CORES-1:0] tag_sharers;

	// Updates from the directory stage
	logic                tag_wr_en;
	logic [SET_BITS-1:0] tag_wr_set;
	way_t                tag_wr_way;
	logic [TAG_BITS-1:0] tag_wr_tag;
	logic                tag_wr_valid;
	logic [NUM_WAYS-1:0] dirty_wr_en;
	logic [SET_BITS-1:0] dirty_wr_set;
	logic                dirty_wr_value;
	logic                lru_upd_en;
	logic [SET_BITS-1:0] lru_upd_set;
	way_t                lru_upd_way;
	logic                shr_upd_en;
	logic [SET_BITS-1:0] shr_upd_set;
	way_t                shr_upd_way;
	core_id_t            shr_upd_core;
	shr_op_e             shr_upd_op;

	l2_cache_tag #(
		.SET_BITS(SET_BITS),
		.NUM_CORES(NUM_CORES)
	) tag_stage_inst (
		.clk(clk),
		.reset(reset),
		.req_i(req_i),
		.tag_req_o(tag_req),
		.tag_tags_o(tag_tags),
		.tag_valid_o(tag_valid),
		.tag_dirty_o(tag_dirty),
		.tag_victim_o(tag_victim),
		.tag_sharers_o(tag_sharers),
		.tag_wr_en_i(tag_wr_en),
		.tag_wr_set_i(tag_wr_set),
		.tag_wr_way_i(tag_wr_way),
		.tag_wr_tag_i(tag_wr_tag),
		.tag_wr_valid_i(tag_wr_valid),
		.dirty_wr_en_i(dirty_wr_en),
		.dirty_wr_set_i(dirty_wr_set),
		.dirty_wr_value_i(dirty_wr_value),
		.lru_upd_en_i(lru_upd_en),
		.lru_upd_set_i(lru_upd_set),
		.lru_upd_way_i(lru_upd_way),
		.shr_upd_en_i(shr_upd_en),
		.shr_upd_set_i(shr_upd_set),
		.shr_upd_way_i(shr_upd_way),
		.shr_upd_core_i(shr_upd_core),
		.shr_upd_op_i(shr_upd_op)
	);

	l2_cache_dir #(
		.SET_BITS(SET_BITS),
		.NUM_CORES(NUM_CORES)
	) dir_stage_inst (
		.clk(clk),
		.reset(reset),
		.tag_req_i(tag_req),
		.tag_tags_i(tag_tags),
		.tag_valid_i(tag_valid),
		.tag_dirty_i(tag_dirty),
		.tag_victim_i(tag_victim),
		.tag_sharers_i(tag_sharers),
		.tag_wr_en_o(tag_wr_en),
		.tag_wr_set_o(tag_wr_set),
		.tag_wr_way_o(tag_wr_way),
		.tag_wr_tag_o(tag_wr_tag),
		.tag_wr_valid_o(tag_wr_valid),
		.dirty_wr_en_o(dirty_wr_en),
		.dirty_wr_set_o(dirty_wr_set),
		.dirty_wr_value_o(dirty_wr_value),
		.lru_upd_en_o(lru_upd_en),
		.lru_upd_set_o(lru_upd_set),
		.lru_upd_way_o(lru_upd_way),
		.shr_upd_en_o(shr_upd_en),
		.shr_upd_set_o(shr_upd_set),
		.shr_upd_way_o(shr_upd_way),
		.shr_upd_core_o(shr_upd_core),
		.shr_upd_op_o(shr_upd_op),
		.resp_o(resp_o)
	);

endmodule

`default_nettype wire

// ==== bench/l2_tags_assertions.sv ====
// Port-level checks on the L2 tag pipeline, bound into every instance of its top level
`timescale 1ns/1ns
`default_nettype none

module l2_tags_assertions
#(
	parameter int NUM_CORES = 4
)
(
	input logic                   clk,
	input logic                   reset,
	input l2_cache_pkg::l2_req_t  req_i,
	input l2_cache_pkg::l2_resp_t resp_i
);

	import l2_cache_pkg::*;

	int failure_count = 0;

	// Two stages, so every request yields a response exactly two edges later
	valid_latency_a: assert property (@(posedge clk) disable iff (reset)
		resp_i.valid == $past(req_i.valid, 2))
	else
	begin
		failure_count++;
		$error("Response valid does not follow request valid by two cycles");
	end

	inval_range_a: assert property (@(posedge clk) disable iff (reset)
		(resp_i.inval_mask >> NUM_CORES) == '0)
	else
	begin
		failure_count++;
		$error("Invalidate mask names a core that does not exist");
	end

	// Loads and stores only write back the line they evict on a miss
	fill_wb_a: assert property (@(posedge clk) disable iff (reset)
		(resp_i.valid && (resp_i.op == L2_LOAD || resp_i.op == L2_STORE))
		|-> !(resp_i.hit && resp_i.writeback))
	else
	begin
		failure_count++;
		$error("Load or store reports both a hit and a writeback");
	end

endmodule

bind l2_cache_tags_top l2_tags_assertions #(
	.NUM_CORES(NUM_CORES)
) assertions_inst (
	.clk(clk),
	.reset(reset),
	.req_i(req_i),
	.resp_i(resp_o)
);

`default_nettype wire

// ==== bench/l2_tags_tb.sv ====
// Testbench for the L2 tag pipeline, replaying the request and response patterns from the bench folder
`timescale 1ns/1ns
`default_nettype none

module l2_tags_tb;

	import l2_cache_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 4;
	localparam int MAX_PATTERNS = 256;

	// One line of the pattern file, every field padded to whole hex digits
	typedef struct packed {
		logic [3:0]  valid;
		logic [3:0]  core;
		logic [3:0]  op;
		logic [19:0] addr;
		logic [3:0]  hit;
		logic [3:0]  way;
		logic [3:0]  writeback;
		logic [19:0] wb_addr;
		logic [15:0] inval_mask;
	} pattern_t;

	logic     clk;
	logic     reset;
	l2_req_t  req;
	l2_resp_t resp;

	logic [$bits(pattern_t)-1:0] pattern_mem [MAX_PATTERNS];
	int num_patterns;

	l2_cache_tags_top #(
		.SET_BITS(4),
		.NUM_CORES(4)
	) l2_cache_tags_top_inst (
		.clk(clk),
		.reset(reset),
		.req_i(req),
		.resp_o(resp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic compare_field(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Response mismatch");
		end
	endtask

	task automatic stop_on_assertion_failure();
		if (l2_cache_tags_top_inst.assertions_inst.failure_count != 0)
		begin
			$display("An assertion on the DUT ports failed before %0t ns", $time);
			$display("STATUS: FAIL");
			$fatal(1, "Assertion failure");
		end
	endtask

	task automatic drive_request(input pattern_t pat);
		req.valid = pat.valid[0];
		req.core = pat.core;
		req.op = l2_op_e'(pat.op[1:0]);
		req.addr = pat.addr;
	endtask

	task automatic check_response(input int index, input pattern_t pat);
		string name;
		logic  fills;
		name = $sformatf("pattern %0d", index);
		fills = l2_op_e'(pat.op[1:0]) inside {L2_LOAD, L2_STORE};
		compare_field({name, " valid"}, resp.valid, pat.valid);
		if (pat.valid[0])
		begin
			compare_field({name, " op"}, resp.op, pat.op);
			compare_field({name, " hit"}, resp.hit, pat.hit);
			compare_field({name, " writeback"}, resp.writeback, pat.writeback);
			compare_field({name, " inval_mask"}, resp.inval_mask, pat.inval_mask);
			// A flush or invalidate that misses touches no way
			if (pat.hit[0] || fills)
				compare_field({name, " way"}, resp.way, pat.way);
			if (pat.writeback[0])
				compare_field({name, " wb_addr"}, resp.wb_addr, pat.wb_addr);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		req = '0;
		num_patterns = 0;

		// Entries past the end of the file keep the all-ones marker
		for (int i = 0; i < MAX_PATTERNS; i++)
			pattern_mem[i] = '1;
		$readmemh("bench/l2_tags_patterns.txt", pattern_mem);
		while (num_patterns < MAX_PATTERNS && pattern_mem[num_patterns][79:76] != 4'hf)
			num_patterns++;

		if (num_patterns == 0)
		begin
			$display("No patterns could be read from the pattern file");
			$display("STATUS: FAIL");
			$fatal(1, "Empty pattern list");
		end

		fork
			begin
				#((num_patterns + 10) * CLK_PERIOD);
				$display("Timeout: the responses to %0d patterns did not arrive in time",
					num_patterns);
				$display("STATUS: FAIL");
				$fatal(1, "Watchdog expired");
			end
		join_none

		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		// Each response is registered two rising edges after its request
		for (int i = 0; i < num_patterns + 2; i++)
		begin
			@(negedge clk);
			stop_on_assertion_failure();
			if (i >= 2)
				check_response(i - 2, pattern_t'(pattern_mem[i - 2]));
			if (i < num_patterns)
				drive_request(pattern_t'(pattern_mem[i]));
			else
				req = '0;
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/l2_tags_patterns.txt ====
// Columns: req valid, core, op (0 load 1 store 2 flush 3 invalidate), line address,
// expected hit, way, writeback, writeback address, invalidate mask
1_0_0_00011_0_0_0_00000_0000
1_0_0_00021_0_2_0_00000_0000
1_0_0_00031_0_1_0_00000_0000
1_0_0_00041_0_3_0_00000_0000
1_1_0_00011_1_0_0_00000_0000
0_0_0_00000_0_0_0_00000_0000
1_2_1_00031_1_1_0_00000_0001
1_3_0_00011_1_0_0_00000_0000
1_3_0_00041_1_3_0_00000_0000
1_1_0_00051_0_1_1_00031_0004
1_0_0_00012_0_0_0_00000_0000
1_2_0_00012_1_0_0_00000_0000
1_1_1_00012_1_0_0_00000_0005
0_0_0_00000_0_0_0_00000_0000
1_1_2_00012_1_0_1_00012_0000
1_1_2_00012_1_0_0_00000_0000
1_3_0_00012_1_0_0_00000_0000
1_0_3_00012_1_0_0_00000_000a
1_0_0_00012_0_2_0_00000_0000
1_0_2_00032_0_0_0_00000_0000
1_0_3_00042_0_0_0_00000_0000
1_1_1_00013_0_0_0_00000_0000
1_1_2_00013_1_0_1_00013_0000
1_2_2_00013_1_0_0_00000_0000
1_2_1_00023_0_2_0_00000_0000
1_3_3_00023_1_2_1_00023_0004
1_3_0_00023_0_1_0_00000_0000
1_0_0_00051_1_1_0_00000_0000
1_2_0_00013_1_0_0_00000_0000

// ==== l2_cache_tags_top.f ====
src/l2_cache_pkg.sv
src/sram_1r1w.sv
src/cache_lru.sv
src/l2_sharer_dir.sv
src/l2_cache_tag.sv
src/l2_cache_dir.sv
src/l2_cache_tags_top.sv
bench/l2_tags_assertions.sv
bench/l2_tags_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache_tags

sources:
  - files:
      - src/l2_cache_pkg.sv
      - src/sram_1r1w.sv
      - src/cache_lru.sv
      - src/l2_sharer_dir.sv
      - src/l2_cache_tag.sv
      - src/l2_cache_dir.sv
      - src/l2_cache_tags_top.sv
  - target: test
    files:
      - bench/l2_tags_assertions.sv
      - bench/l2_tags_tb.sv
